//--- source/spr_exchange_pkg.sv
package spr_exchange_pkg;

	// Data and address width
	localparam int WORD_W = 32;

	// Task id bits that select a table entry
	localparam int TID_W = 14;

	// Each entry is 256 bytes
	localparam int TST_ENTRY_SHIFT = 8;

	// Stack pointer slots inside an entry, byte offsets
	localparam logic [WORD_W-1:0] TST_USPR_OFFSET = 32'h0000_0010;
	localparam logic [WORD_W-1:0] TST_KSPR_OFFSET = 32'h0000_0014;

	// Entry layout, in words
	//   0x10  user mode stack pointer
	//   0x14  kernel mode stack pointer
	// All other words of an entry belong to other
	// parts of the task state and are not touched here

	// The entry index is built from the low TID_W bits of TIDR.
	// With a 32 bit address this leaves room for
	// 14 + 8 = 22 bits of entry offset above the table base,
	// so the table must not sit within 4 MB of the top of the address space

endpackage

//--- source/mode_switch_request.sv
`timescale 1ns/100ps
`default_nettype none

module mode_switch_request (
	input  logic                                iCLOCK,
	input  logic                                inRESET,
	input  logic                                iRESET_SYNC,
	input  logic                                switch_req,       // One cycle strobe
	input  logic                                switch_to_kernel, // 1: user to kernel
	input  logic [spr_exchange_pkg::WORD_W-1:0] spr,
	input  logic [spr_exchange_pkg::WORD_W-1:0] tisr,
	input  logic [spr_exchange_pkg::WORD_W-1:0] tidr,
	input  logic                                finish,
	output logic                                switch_busy,
	output logic                                exch_start,
	output logic                                exch_kernel,
	output logic [spr_exchange_pkg::WORD_W-1:0] snap_spr,
	output logic [spr_exchange_pkg::WORD_W-1:0] snap_tisr,
	output logic [spr_exchange_pkg::WORD_W-1:0] snap_tidr
);

	logic accept;

	// Strobes during an exchange are dropped
	assign accept = switch_req && !switch_busy;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			switch_busy <= 1'b0;
			exch_start  <= 1'b0;
		end else if (iRESET_SYNC) begin
			switch_busy <= 1'b0;
			exch_start  <= 1'b0;
		end else begin
			exch_start <= accept;
			if (accept) begin
				switch_busy <= 1'b1;
			end else if (finish) begin
				switch_busy <= 1'b0; // Drops the cycle after finish
			end
		end
	end

	// Snapshot of direction and system registers, frozen for the whole exchange
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			exch_kernel <= switch_to_kernel;
			snap_spr    <= spr;
			snap_tisr   <= tisr;
			snap_tidr   <= tidr;
		end
	end

endmodule

`default_nettype wire

//--- source/spr_exchange_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module spr_exchange_fsm (
	input  logic                                iCLOCK,
	input  logic                                inRESET,
	input  logic                                iRESET_SYNC,
	input  logic                                exch_start,
	input  logic                                exch_kernel, // Target mode
	input  logic [spr_exchange_pkg::WORD_W-1:0] snap_spr,
	input  logic [spr_exchange_pkg::WORD_W-1:0] snap_tisr,
	input  logic [spr_exchange_pkg::WORD_W-1:0] snap_tidr,
	input  logic                                ldst_busy,
	input  logic                                ldst_ack,
	input  logic [spr_exchange_pkg::WORD_W-1:0] ldst_rdata,
	output logic                                ldst_use,
	output logic                                ldst_req,
	output logic                                ldst_we,
	output logic [spr_exchange_pkg::WORD_W-1:0] ldst_addr,
	output logic [spr_exchange_pkg::WORD_W-1:0] ldst_wdata,
	output logic                                finish,
	output logic [spr_exchange_pkg::WORD_W-1:0] finish_spr
);

	import spr_exchange_pkg::*;

	localparam logic [2:0] ST_IDLE       = 3'd0;
	localparam logic [2:0] ST_LOAD_REQ   = 3'd1;
	localparam logic [2:0] ST_LOAD_WAIT  = 3'd2;
	localparam logic [2:0] ST_STORE_REQ  = 3'd3;
	localparam logic [2:0] ST_STORE_WAIT = 3'd4;

	logic [2:0]        state_q;
	logic [2:0]        state_d;
	logic              issue;
	logic [WORD_W-1:0] entry_base;
	logic [WORD_W-1:0] uspr_addr;
	logic [WORD_W-1:0] kspr_addr;
	logic [WORD_W-1:0] load_addr;
	logic [WORD_W-1:0] store_addr;

	// Entry of the current task in the task state table
	assign entry_base = snap_tisr +
		(WORD_W'(snap_tidr[TID_W-1:0]) << TST_ENTRY_SHIFT);
	assign uspr_addr  = entry_base + TST_USPR_OFFSET;
	assign kspr_addr  = entry_base + TST_KSPR_OFFSET;

	// Load from the target mode slot, store into the mode being left
	assign load_addr  = exch_kernel ? kspr_addr : uspr_addr;
	assign store_addr = exch_kernel ? uspr_addr : kspr_addr;

	// Request goes out only when the port is free
	assign issue = ((state_q == ST_LOAD_REQ) || (state_q == ST_STORE_REQ)) && !ldst_busy;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (exch_start) begin
					state_d = ST_LOAD_REQ;
				end
			end
			ST_LOAD_REQ: begin
				if (!ldst_busy) begin
					state_d = ST_LOAD_WAIT;
				end
			end
			ST_LOAD_WAIT: begin
				if (ldst_ack) begin
					state_d = ST_STORE_REQ;
				end
			end
			ST_STORE_REQ: begin
				if (!ldst_busy) begin
					state_d = ST_STORE_WAIT;
				end
			end
			ST_STORE_WAIT: begin
				if (ldst_ack) begin
					state_d = ST_IDLE;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q <= ST_IDLE;
		end else if (iRESET_SYNC) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Registered load/store controls and finish strobe
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ldst_use <= 1'b0;
			ldst_req <= 1'b0;
			ldst_we  <= 1'b0;
			finish   <= 1'b0;
		end else if (iRESET_SYNC) begin
			ldst_use <= 1'b0;
			ldst_req <= 1'b0;
			ldst_we  <= 1'b0;
			finish   <= 1'b0;
		end else begin
			ldst_use <= (state_d != ST_IDLE); // Held over the whole exchange
			ldst_req <= issue;
			if (issue) begin
				ldst_we <= (state_q == ST_STORE_REQ);
			end
			finish <= (state_q == ST_STORE_WAIT) && ldst_ack;
		end
	end

	// Address and data of the access being issued
	always_ff @(posedge iCLOCK) begin
		if (issue) begin
			ldst_addr  <= (state_q == ST_STORE_REQ) ? store_addr : load_addr;
			ldst_wdata <= snap_spr; // Outgoing stack pointer
		end
	end

	// Incoming stack pointer, kept until the next load returns
	always_ff @(posedge iCLOCK) begin
		if ((state_q == ST_LOAD_WAIT) && ldst_ack) begin
			finish_spr <= ldst_rdata;
		end
	end

endmodule

`default_nettype wire

//--- source/tst_memory_port.sv
`timescale 1ns/100ps
`default_nettype none

module tst_memory_port #(
	parameter int MEM_WORDS   = 1024,
	parameter int MEM_LATENCY = 2      // 1 to 7 cycles
) (
	input  logic                                iCLOCK,
	input  logic                                inRESET,
	input  logic                                iRESET_SYNC,
	input  logic                                ldst_use,
	input  logic                                ldst_req,
	input  logic                                ldst_we,
	input  logic [spr_exchange_pkg::WORD_W-1:0] ldst_addr,   // Byte address
	input  logic [spr_exchange_pkg::WORD_W-1:0] ldst_wdata,
	output logic                                ldst_busy,
	output logic                                ldst_ack,
	output logic [spr_exchange_pkg::WORD_W-1:0] ldst_rdata,
	input  logic                                preload_we,
	input  logic [spr_exchange_pkg::WORD_W-1:0] preload_addr, // Word address
	input  logic [spr_exchange_pkg::WORD_W-1:0] preload_data
);

	import spr_exchange_pkg::*;

	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	logic [WORD_W-1:0] mem [MEM_WORDS];

	logic              busy_q;
	logic [2:0]        cnt_q;
	logic              accept;
	logic              we_q;
	logic [IDX_W-1:0]  idx_q;
	logic [WORD_W-1:0] wdata_q;

	// Word index wrapped to the array size
	function automatic logic [IDX_W-1:0] word_index(input logic [WORD_W-1:0] word_addr);
		logic [WORD_W-1:0] wrapped;
		wrapped = word_addr % WORD_W'(MEM_WORDS);
		return wrapped[IDX_W-1:0];
	endfunction

	assign accept = ldst_use && ldst_req && !busy_q;

	// Countdown of the access latency
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			busy_q <= 1'b0;
			cnt_q  <= 3'd0;
		end else if (iRESET_SYNC) begin
			busy_q <= 1'b0;
			cnt_q  <= 3'd0;
		end else if (ldst_ack) begin
			busy_q <= 1'b0;
		end else if (accept) begin
			busy_q <= 1'b1;
			cnt_q  <= 3'(MEM_LATENCY);
		end else if (busy_q) begin
			cnt_q <= cnt_q - 3'd1;
		end
	end

	// Busy from the cycle after the request through the ack cycle
	assign ldst_busy = busy_q;
	assign ldst_ack  = busy_q && (cnt_q == 3'd1);

	// Latched request
	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			we_q    <= ldst_we;
			idx_q   <= word_index(ldst_addr >> 2);
			wdata_q <= ldst_wdata;
		end
	end

	// Array writes, store completion or preload
	always_ff @(posedge iCLOCK) begin
		if (ldst_ack && we_q) begin
			mem[idx_q] <= wdata_q;
		end
		if (preload_we) begin
			mem[word_index(preload_addr)] <= preload_data; // Only while no exchange runs
		end
	end

	// Valid together with ack
	assign ldst_rdata = mem[idx_q];

endmodule

`default_nettype wire

//--- source/spr_exchange_top.sv
`timescale 1ns/100ps
`default_nettype none

module spr_exchange_top #(
	parameter int MEM_WORDS   = 1024,
	parameter int MEM_LATENCY = 2
) (
	input  logic                                iCLOCK,
	input  logic                                inRESET,
	input  logic                                iRESET_SYNC,
	input  logic                                switch_req,
	input  logic                                switch_to_kernel,
	input  logic [spr_exchange_pkg::WORD_W-1:0] spr,
	input  logic [spr_exchange_pkg::WORD_W-1:0] tisr,
	input  logic [spr_exchange_pkg::WORD_W-1:0] tidr,
	output logic                                switch_busy,
	output logic                                finish,
	output logic [spr_exchange_pkg::WORD_W-1:0] finish_spr,
	input  logic                                preload_we,
	input  logic [spr_exchange_pkg::WORD_W-1:0] preload_addr,
	input  logic [spr_exchange_pkg::WORD_W-1:0] preload_data
);

	import spr_exchange_pkg::*;

	// Request snapshot
	logic              exch_start;
	logic              exch_kernel;
	logic [WORD_W-1:0] snap_spr;
	logic [WORD_W-1:0] snap_tisr;
	logic [WORD_W-1:0] snap_tidr;

	// Load/store path
	logic              ldst_use;
	logic              ldst_req;
	logic              ldst_we;
	logic [WORD_W-1:0] ldst_addr;
	logic [WORD_W-1:0] ldst_wdata;
	logic              ldst_busy;
	logic              ldst_ack;
	logic [WORD_W-1:0] ldst_rdata;

	mode_switch_request req_i (
		.iCLOCK           (iCLOCK),
		.inRESET          (inRESET),
		.iRESET_SYNC      (iRESET_SYNC),
		.switch_req       (switch_req),
		.switch_to_kernel (switch_to_kernel),
		.spr              (spr),
		.tisr             (tisr),
		.tidr             (tidr),
		.finish           (finish),
		.switch_busy      (switch_busy),
		.exch_start       (exch_start),
		.exch_kernel      (exch_kernel),
		.snap_spr         (snap_spr),
		.snap_tisr        (snap_tisr),
		.snap_tidr        (snap_tidr)
	);

	spr_exchange_fsm fsm_i (
		.iCLOCK      (iCLOCK),
		.inRESET     (inRESET),
		.iRESET_SYNC (iRESET_SYNC),
		.exch_start  (exch_start),
		.exch_kernel (exch_kernel),
		.snap_spr    (snap_spr),
		.snap_tisr   (snap_tisr),
		.snap_tidr   (snap_tidr),
		.ldst_busy   (ldst_busy),
		.ldst_ack    (ldst_ack),
		.ldst_rdata  (ldst_rdata),
		.ldst_use    (ldst_use),
		.ldst_req    (ldst_req),
		.ldst_we     (ldst_we),
		.ldst_addr   (ldst_addr),
		.ldst_wdata  (ldst_wdata),
		.finish      (finish),
		.finish_spr  (finish_spr)
	);

	tst_memory_port #(
		.MEM_WORDS   (MEM_WORDS),
		.MEM_LATENCY (MEM_LATENCY)
	) mem_i (
		.iCLOCK       (iCLOCK),
		.inRESET      (inRESET),
		.iRESET_SYNC  (iRESET_SYNC),
		.ldst_use     (ldst_use),
		.ldst_req     (ldst_req),
		.ldst_we      (ldst_we),
		.ldst_addr    (ldst_addr),
		.ldst_wdata   (ldst_wdata),
		.ldst_busy    (ldst_busy),
		.ldst_ack     (ldst_ack),
		.ldst_rdata   (ldst_rdata),
		.preload_we   (preload_we),
		.preload_addr (preload_addr),
		.preload_data (preload_data)
	);

endmodule

`default_nettype wire

//--- tests/spr_exchange_assert.sv
`timescale 1ns/100ps

module spr_exchange_assert #(
	parameter int MEM_WORDS = 1024
) (
	input logic                                iCLOCK,
	input logic                                inRESET,
	input logic                                iRESET_SYNC,
	input logic                                switch_req,
	input logic                                switch_to_kernel,
	input logic [spr_exchange_pkg::WORD_W-1:0] spr,
	input logic [spr_exchange_pkg::WORD_W-1:0] tisr,
	input logic [spr_exchange_pkg::WORD_W-1:0] tidr,
	input logic                                switch_busy,
	input logic                                finish,
	input logic [spr_exchange_pkg::WORD_W-1:0] finish_spr,
	input logic                                preload_we,
	input logic [spr_exchange_pkg::WORD_W-1:0] preload_addr,
	input logic [spr_exchange_pkg::WORD_W-1:0] preload_data,
	input logic                                ldst_req,
	input logic                                ldst_we,
	input logic [spr_exchange_pkg::WORD_W-1:0] ldst_addr,
	input logic [spr_exchange_pkg::WORD_W-1:0] ldst_wdata,
	input logic                                ldst_ack
);

	import spr_exchange_pkg::*;

	int unsigned       fail_count;
	logic [WORD_W-1:0] shadow [MEM_WORDS]; // Expected table contents
	logic              req_kernel;
	logic [WORD_W-1:0] req_spr;
	logic [WORD_W-1:0] req_tisr;
	logic [WORD_W-1:0] req_tidr;
	logic              pending;            // Accepted switch without finish yet
	logic              st_pending;         // Store issued, not yet acknowledged
	logic [WORD_W-1:0] st_addr;
	logic [WORD_W-1:0] st_data;
	logic [WORD_W-1:0] tid_ext;
	logic [WORD_W-1:0] entry;
	logic [WORD_W-1:0] tgt_addr;
	logic [WORD_W-1:0] src_addr;
	logic [WORD_W-1:0] exp_load;
	logic [WORD_W-1:0] src_slot;

	function automatic int unsigned word_slot(input logic [WORD_W-1:0] word_addr);
		return word_addr % MEM_WORDS;
	endfunction

	initial fail_count = 0;

	// Slots of the accepted request, task id times 256 above the base
	assign tid_ext  = {{(WORD_W-TID_W){1'b0}}, req_tidr[TID_W-1:0]};
	assign entry    = req_tisr + (tid_ext << TST_ENTRY_SHIFT);
	assign tgt_addr = entry + (req_kernel ? TST_KSPR_OFFSET : TST_USPR_OFFSET);
	assign src_addr = entry + (req_kernel ? TST_USPR_OFFSET : TST_KSPR_OFFSET);
	assign exp_load = shadow[word_slot(tgt_addr >> 2)];
	assign src_slot = shadow[word_slot(src_addr >> 2)];

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pending    <= 1'b0;
			st_pending <= 1'b0;
		end else if (iRESET_SYNC) begin
			pending    <= 1'b0;
			st_pending <= 1'b0;
		end else begin
			if (switch_req && !switch_busy) begin
				pending <= 1'b1;
			end else if (finish) begin
				pending <= 1'b0;
			end
			if (ldst_req && ldst_we) begin
				st_pending <= 1'b1;
			end else if (ldst_ack) begin
				st_pending <= 1'b0;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (switch_req && !switch_busy) begin
			req_kernel <= switch_to_kernel;
			req_spr    <= spr;
			req_tisr   <= tisr;
			req_tidr   <= tidr;
		end
		if (ldst_req && ldst_we) begin
			st_addr <= ldst_addr;
			st_data <= ldst_wdata;
		end
	end

	// Table follows preloads and completed stores
	always_ff @(posedge iCLOCK) begin
		if (preload_we) begin
			shadow[word_slot(preload_addr)] <= preload_data;
		end
		if (st_pending && ldst_ack) begin
			shadow[word_slot(st_addr >> 2)] <= st_data;
		end
	end

	finish_one_cycle: assert property (@(posedge iCLOCK) disable iff (!inRESET || iRESET_SYNC)
		finish |=> !finish)
		else begin
			fail_count++;
			$error("finish stayed high for more than one cycle");
		end

	finish_while_busy: assert property (@(posedge iCLOCK) disable iff (!inRESET || iRESET_SYNC)
		finish |-> (switch_busy && pending))
		else begin
			fail_count++;
			$error("finish pulse without an open switch request");
		end

	load_value: assert property (@(posedge iCLOCK) disable iff (!inRESET || iRESET_SYNC)
		finish |-> (finish_spr == exp_load))
		else begin
			fail_count++;
			$error("FAIL finish_spr: got %h expected %h", $sampled(finish_spr), $sampled(exp_load));
		end

	store_value: assert property (@(posedge iCLOCK) disable iff (!inRESET || iRESET_SYNC)
		finish |-> (src_slot == req_spr))
		else begin
			fail_count++;
			$error("FAIL ldst_wdata at %h: got %h expected %h",
				$sampled(src_addr), $sampled(src_slot), $sampled(req_spr));
		end

	// Checked one edge later, once the asynchronous clear has surely taken effect
	idle_in_reset: assert property (@(posedge iCLOCK)
		!inRESET |=> (!switch_busy && !finish))
		else begin
			fail_count++;
			$error("switch_busy or finish high during reset");
		end

	idle_after_sync_reset: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		iRESET_SYNC |=> (!switch_busy && !finish))
		else begin
			fail_count++;
			$error("switch_busy or finish high after synchronous reset");
		end

endmodule

bind spr_exchange_top spr_exchange_assert #(
	.MEM_WORDS (MEM_WORDS)
) chk_i (
	.iCLOCK           (iCLOCK),
	.inRESET          (inRESET),
	.iRESET_SYNC      (iRESET_SYNC),
	.switch_req       (switch_req),
	.switch_to_kernel (switch_to_kernel),
	.spr              (spr),
	.tisr             (tisr),
	.tidr             (tidr),
	.switch_busy      (switch_busy),
	.finish           (finish),
	.finish_spr       (finish_spr),
	.preload_we       (preload_we),
	.preload_addr     (preload_addr),
	.preload_data     (preload_data),
	.ldst_req         (ldst_req),
	.ldst_we          (ldst_we),
	.ldst_addr        (ldst_addr),
	.ldst_wdata       (ldst_wdata),
	.ldst_ack         (ldst_ack)
);

//--- tests/tb_spr_exchange.sv
`timescale 1ns/100ps

module tb_spr_exchange;

	import spr_exchange_pkg::*;

	localparam int MEM_WORDS   = 1024;
	localparam int MEM_LATENCY = 2;
	localparam int CLK_PERIOD  = 4;
	localparam int N_SWITCH    = 40;
	localparam int WAIT_LIMIT  = 40;  // Cycles allowed per exchange
	localparam int CYCLE_LIMIT = 8 + MEM_WORDS + N_SWITCH * WAIT_LIMIT;

	logic              iCLOCK;
	logic              inRESET;
	logic              iRESET_SYNC;
	logic              switch_req;
	logic              switch_to_kernel;
	logic [WORD_W-1:0] spr;
	logic [WORD_W-1:0] tisr;
	logic [WORD_W-1:0] tidr;
	logic              switch_busy;
	logic              finish;
	logic [WORD_W-1:0] finish_spr;
	logic              preload_we;
	logic [WORD_W-1:0] preload_addr;
	logic [WORD_W-1:0] preload_data;

	int                tb_errors;
	int                total_errors;
	int                switches;
	int                finishes;
	int                tid;
	logic              kernel;
	logic [WORD_W-1:0] base;
	logic [WORD_W-1:0] slot_addr;

	spr_exchange_top #(
		.MEM_WORDS   (MEM_WORDS),
		.MEM_LATENCY (MEM_LATENCY)
	) dut_i (
		.iCLOCK           (iCLOCK),
		.inRESET          (inRESET),
		.iRESET_SYNC      (iRESET_SYNC),
		.switch_req       (switch_req),
		.switch_to_kernel (switch_to_kernel),
		.spr              (spr),
		.tisr             (tisr),
		.tidr             (tidr),
		.switch_busy      (switch_busy),
		.finish           (finish),
		.finish_spr       (finish_spr),
		.preload_we       (preload_we),
		.preload_addr     (preload_addr),
		.preload_data     (preload_data)
	);

	initial begin
		iCLOCK = 1'b0;
		forever #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;
	end

	initial begin
		#(CYCLE_LIMIT * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, exchange sequence did not complete", CYCLE_LIMIT);
		$display("TESTS FAILED");
		$finish;
	end

	// Drive point, 1 ns after the rising edge
	task automatic step();
		@(posedge iCLOCK);
		#1;
	endtask

	task automatic preload_write(input logic [WORD_W-1:0] word_addr, input logic [WORD_W-1:0] data);
		preload_we   = 1'b1;
		preload_addr = word_addr;
		preload_data = data;
		step();
		preload_we   = 1'b0;
	endtask

	task automatic wait_finish();
		int n;
		n = 0;
		while (finish !== 1'b1 && n < WAIT_LIMIT) begin
			step();
			n++;
		end
		if (finish === 1'b1) begin
			finishes++;
		end else begin
			tb_errors++;
			$display("No finish pulse within %0d cycles of switch request %0d", WAIT_LIMIT, switches);
		end
	endtask

	task automatic strobe(input logic to_kernel, input logic [WORD_W-1:0] tbase,
		input logic [WORD_W-1:0] tid_word, input logic [WORD_W-1:0] sp);
		switch_to_kernel = to_kernel;
		tisr             = tbase;
		tidr             = tid_word;
		spr              = sp;
		switch_req       = 1'b1;
		step();
		switch_req = 1'b0;
		switches++;
		spr  = $urandom; // Live registers move on, snapshot must hold
		tisr = $urandom;
		tidr = $urandom;
	endtask

	task automatic do_switch(input logic to_kernel, input logic [WORD_W-1:0] tbase,
		input logic [WORD_W-1:0] tid_word, input logic [WORD_W-1:0] sp, input bit extra);
		strobe(to_kernel, tbase, tid_word, sp);
		if (extra) begin
			switch_req       = 1'b1; // Lands while busy
			switch_to_kernel = !to_kernel;
			step();
			switch_req = 1'b0;
		end
		wait_finish();
		step();
	endtask

	// Sync reset during the load phase, before any store
	task automatic abort_switch(input logic to_kernel, input logic [WORD_W-1:0] tbase,
		input logic [WORD_W-1:0] tid_word);
		strobe(to_kernel, tbase, tid_word, $urandom);
		step();
		iRESET_SYNC = 1'b1;
		step();
		iRESET_SYNC = 1'b0;
		switches--;
		step();
	endtask

	initial begin
		void'($urandom(42));
		inRESET          = 1'b0;
		iRESET_SYNC      = 1'b0;
		switch_req       = 1'b0;
		switch_to_kernel = 1'b0;
		spr              = '0;
		tisr             = '0;
		tidr             = '0;
		preload_we       = 1'b0;
		preload_addr     = '0;
		preload_data     = '0;
		tb_errors        = 0;
		switches         = 0;
		finishes         = 0;
		kernel           = 1'b0;
		base             = '0;
		tid              = 0;
		repeat (8) step();
		inRESET = 1'b1;
		step();

		for (int i = 0; i < MEM_WORDS; i++) begin
			preload_write(i, $urandom);
		end

		for (int k = 0; k < N_SWITCH; k++) begin
			if (k % 2 == 1) begin
				kernel = !kernel; // Reloads the slot stored just before
			end else begin
				kernel = $urandom_range(0, 1);
				base   = $urandom & 32'h003F_FFFC;
				tid    = $urandom_range(0, 63);
			end
			if (k % 6 == 4) begin
				slot_addr = base + (tid << TST_ENTRY_SHIFT) +
					(kernel ? TST_KSPR_OFFSET : TST_USPR_OFFSET);
				preload_write(slot_addr >> 2, $urandom);
			end
			if (k == 20) begin
				abort_switch(kernel, base, ($urandom << TID_W) | tid);
			end else begin
				do_switch(kernel, base, ($urandom << TID_W) | tid, $urandom, (k % 4 == 2));
			end
		end

		repeat (4) step();
		total_errors = tb_errors + dut_i.chk_i.fail_count;
		$display("Switches %0d, finishes %0d, assertion failures %0d, testbench errors %0d",
			switches, finishes, dut_i.chk_i.fail_count, tb_errors);
		if (total_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- all.f
source/spr_exchange_pkg.sv
source/mode_switch_request.sv
source/spr_exchange_fsm.sv
source/tst_memory_port.sv
source/spr_exchange_top.sv
tests/spr_exchange_assert.sv
tests/tb_spr_exchange.sv

//--- Bender.yml
package:
  name: spr_exchange

sources:
  # Package first, then the blocks, then the top level
  - files:
      - source/spr_exchange_pkg.sv
      - source/mode_switch_request.sv
      - source/spr_exchange_fsm.sv
      - source/tst_memory_port.sv
      - source/spr_exchange_top.sv

  # Bound checker and testbench
  - target: test
    files:
      - tests/spr_exchange_assert.sv
      - tests/tb_spr_exchange.sv
